// File: include/mips_defs.svh
// MIPS core memory sizes, register count and APB address map
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Memory depths in 32-bit words
`define MIPS_IMEM_DEPTH 512
`define MIPS_DMEM_DEPTH 512

`define MIPS_NUM_REGS 32

// APB byte address space
`define MIPS_APB_ADDR_W 13

`define MIPS_APB_IMEM_BASE 13'h0000
`define MIPS_APB_DMEM_BASE 13'h0800
`define MIPS_APB_REG_BASE  13'h1000
`define MIPS_APB_CTRL_ADDR 13'h1080  // Run/status register

`define MIPS_APB_WORD_LSB 2  // Byte address to word index

`endif

// File: hw/mips_isa_pkg.sv
// MIPS ISA types, opcode and instruction class encodings
`default_nettype none

`include "mips_defs.svh"

package mips_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [$clog2(`MIPS_NUM_REGS)-1:0] reg_idx_t;
  typedef logic [15:0] imm_t;
  typedef logic [$clog2(`MIPS_IMEM_DEPTH)-1:0] pc_t;   // Word address
  typedef logic [$clog2(`MIPS_DMEM_DEPTH)-1:0] daddr_t;

  typedef enum logic [5:0] {
    ADD   = 6'd0,
    SUB   = 6'd1,
    AND   = 6'd2,
    OR    = 6'd3,
    SLT   = 6'd4,
    MUL   = 6'd5,
    LW    = 6'd6,
    SW    = 6'd7,
    ADDI  = 6'd8,
    SUBI  = 6'd9,
    BEQZ  = 6'd10,
    BNEQZ = 6'd11,
    HLT   = 6'h3f
  } opcode_e;

  typedef enum logic [2:0] {
    RR      = 3'd0,
    RM      = 3'd1,
    LOAD    = 3'd2,
    STORE   = 3'd3,
    BRANCH  = 3'd4,
    ILLEGAL = 3'd6,
    HALT    = 3'd7
  } iclass_e;

  // Field extraction
  function automatic opcode_e op_of(instr_t i);
    return opcode_e'(i[31:26]);
  endfunction

  function automatic reg_idx_t rs_of(instr_t i);
    return i[25:21];
  endfunction

  function automatic reg_idx_t rt_of(instr_t i);
    return i[20:16];
  endfunction

  function automatic reg_idx_t rd_of(instr_t i);
    return i[15:11];
  endfunction

  function automatic imm_t imm_of(instr_t i);
    return i[15:0];
  endfunction

endpackage

`default_nettype wire

// File: hw/mips_bus_pkg.sv
// APB bus types and core run state encoding
`default_nettype none

`include "mips_defs.svh"

package mips_bus_pkg;

  typedef logic [`MIPS_APB_ADDR_W-1:0] paddr_t;
  typedef logic [31:0] pdata_t;

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    RUNNING = 2'd1,
    HALTED  = 2'd2
  } run_state_e;

endpackage

`default_nettype wire

// File: hw/mips_stage_if.sv
// Pipeline stage registers and host memory access bundles
`default_nettype none

interface if_id_if import mips_isa_pkg::*; ();
  logic   valid;
  instr_t instr;
  pc_t    npc;

  modport driver   (output valid, instr, npc);
  modport receiver (input  valid, instr, npc);
endinterface

interface id_ex_if import mips_isa_pkg::*; ();
  logic    valid;
  instr_t  instr;
  iclass_e iclass;
  pc_t     npc;
  word_t   a;
  word_t   b;
  word_t   imm;  // Already sign extended

  modport driver   (output valid, instr, iclass, npc, a, b, imm);
  modport receiver (input  valid, instr, iclass, npc, a, b, imm);
endinterface

interface ex_mem_if import mips_isa_pkg::*; ();
  logic     valid;
  iclass_e  iclass;
  reg_idx_t dest;
  word_t    result;      // ALU value or data address
  word_t    store_data;

  modport driver   (output valid, iclass, dest, result, store_data);
  modport receiver (input  valid, iclass, dest, result, store_data);
endinterface

interface host_mem_if import mips_isa_pkg::*; ();
  logic   imem_we;
  logic   dmem_we;
  logic   dmem_re;
  daddr_t addr;  // Word index, shared by both memories
  word_t  wdata;
  word_t  dmem_rdata;

  modport master  (output imem_we, dmem_we, dmem_re, addr, wdata, input dmem_rdata);
  modport imem_wr (input imem_we, addr, wdata);
  modport dmem    (input dmem_we, dmem_re, addr, wdata, output dmem_rdata);
endinterface

`default_nettype wire

// File: hw/apb_mem_port.sv
// APB slave for host access to memories, registers and run control
`default_nettype none

`include "mips_defs.svh"

module apb_mem_port import mips_isa_pkg::*, mips_bus_pkg::*; (
  input  logic              clk_1,
  input  logic              rst,
  input  paddr_t            paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  pdata_t            pwdata,
  output pdata_t            prdata,
  output logic              pready,
  output logic              pslverr,
  host_mem_if.master        host,
  output reg_idx_t          reg_idx,
  input  word_t             reg_rdata,
  input  logic              halt_seen,
  output logic              run,
  output logic              halted
);

  run_state_e state;
  logic       setup;
  logic       access;
  logic       in_imem;
  logic       in_dmem;
  logic       in_reg;
  logic       in_ctrl;
  logic       mem_wr;

  assign setup   = psel & ~penable;
  assign access  = psel & penable;
  assign in_imem = paddr < `MIPS_APB_DMEM_BASE;
  assign in_dmem = (paddr >= `MIPS_APB_DMEM_BASE) && (paddr < `MIPS_APB_REG_BASE);
  assign in_reg  = (paddr >= `MIPS_APB_REG_BASE) && (paddr < `MIPS_APB_CTRL_ADDR);
  assign in_ctrl = paddr == `MIPS_APB_CTRL_ADDR;

  // Error flag was settled in the setup phase
  assign mem_wr = access & pwrite & ~pslverr;

  assign host.addr    = daddr_t'(paddr >> `MIPS_APB_WORD_LSB);  // Low word index bits serve both memories
  assign host.wdata   = pwdata;
  assign host.imem_we = mem_wr & in_imem;
  assign host.dmem_we = mem_wr & in_dmem;
  assign host.dmem_re = setup & ~pwrite & in_dmem;
  assign reg_idx = reg_idx_t'((paddr - `MIPS_APB_REG_BASE) >> `MIPS_APB_WORD_LSB);

  assign run    = state == RUNNING;
  assign halted = state == HALTED;

  always_ff @(posedge clk_1 or negedge rst) begin
    if (!rst) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
      state   <= IDLE;
    end else begin
      pready  <= setup;  // No wait states
      pslverr <= setup & pwrite & (in_imem | in_dmem) & run;
      case (state)
        RUNNING: if (halt_seen) state <= HALTED;
        default: if (access && pwrite && in_ctrl && pwdata[0]) state <= RUNNING;
      endcase
    end
  end

  // Read data captured in setup, presented in access
  always_ff @(posedge clk_1) begin
    if (setup && !pwrite) begin
      if (in_dmem) prdata <= host.dmem_rdata;
      else if (in_reg) prdata <= reg_rdata;
      else if (in_ctrl) prdata <= pdata_t'(state);
      else prdata <= '0;  // Instruction memory is write only
    end
  end

endmodule

`default_nettype wire

// File: hw/mips_fetch.sv
// Fetch stage with program counter, instruction memory and branch redirect
`default_nettype none

`include "mips_defs.svh"

module mips_fetch import mips_isa_pkg::*; (
  input  logic        clk_1,
  input  logic        rst,
  input  logic        run,
  host_mem_if.imem_wr host,
  input  logic        redirect,
  input  pc_t         redirect_pc,
  if_id_if.driver     out
);

  instr_t imem [`MIPS_IMEM_DEPTH];
  pc_t    pc;

  always_ff @(posedge clk_1 or negedge rst) begin
    if (!rst) begin
      pc        <= '0;
      out.valid <= 1'b0;
    end else if (!run) begin
      pc        <= '0;  // Ready for the next start
      out.valid <= 1'b0;
    end else if (redirect) begin
      pc        <= redirect_pc;
      out.valid <= 1'b0;  // Drop the wrong-path fetch
    end else begin
      pc        <= pc + pc_t'(1);
      out.valid <= 1'b1;
    end
  end

  always_ff @(posedge clk_1) begin
    out.instr <= imem[pc];
    out.npc   <= pc + pc_t'(1);
  end

  // Host program load
  always_ff @(posedge clk_1) begin
    if (host.imem_we) begin
      imem[host.addr] <= host.wdata;
    end
  end

endmodule

`default_nettype wire

// File: hw/mips_regfile.sv
// General purpose register file with host read port
`default_nettype none

`include "mips_defs.svh"

module mips_regfile import mips_isa_pkg::*; (
  input  logic     clk_1,
  input  logic     rst,
  input  reg_idx_t rs_idx,
  input  reg_idx_t rt_idx,
  output word_t    rs_data,
  output word_t    rt_data,
  input  logic     wb_en,
  input  reg_idx_t wb_idx,
  input  word_t    wb_data,
  input  reg_idx_t reg_idx,
  output word_t    reg_rdata
);

  word_t regs [`MIPS_NUM_REGS];

  assign rs_data   = regs[rs_idx];
  assign rt_data   = regs[rt_idx];
  assign reg_rdata = regs[reg_idx];

  always_ff @(posedge clk_1 or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_idx != '0) begin  // r0 stays zero
      regs[wb_idx] <= wb_data;
    end
  end

endmodule

`default_nettype wire

// File: hw/mips_decode.sv
// Decode stage with operand read, immediate extension and classification
`default_nettype none

module mips_decode import mips_isa_pkg::*; (
  input  logic      clk_1,
  input  logic      rst,
  input  logic      run,
  input  logic      redirect,
  if_id_if.receiver in,
  output reg_idx_t  rs_idx,
  output reg_idx_t  rt_idx,
  input  word_t     rs_data,
  input  word_t     rt_data,
  id_ex_if.driver   out
);

  imm_t    raw_imm;
  iclass_e iclass;

  function automatic iclass_e classify(opcode_e op);
    case (op)
      ADD, SUB, AND, OR, SLT, MUL: return RR;
      ADDI, SUBI:                  return RM;
      LW:                          return LOAD;
      SW:                          return STORE;
      BEQZ, BNEQZ:                 return BRANCH;
      HLT:                         return HALT;
      default:                     return ILLEGAL;  // Retires as a no-op
    endcase
  endfunction

  assign rs_idx  = rs_of(in.instr);
  assign rt_idx  = rt_of(in.instr);
  assign raw_imm = imm_of(in.instr);
  assign iclass  = classify(op_of(in.instr));

  always_ff @(posedge clk_1 or negedge rst) begin
    if (!rst) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= run & in.valid & ~redirect;  // Squash on taken branch
    end
  end

  always_ff @(posedge clk_1) begin
    out.instr  <= in.instr;
    out.iclass <= iclass;
    out.npc    <= in.npc;
    out.a      <= rs_data;
    out.b      <= rt_data;
    out.imm    <= {{16{raw_imm[15]}}, raw_imm};
  end

endmodule

`default_nettype wire

// File: hw/mips_execute.sv
// Execute stage with ALU, address generation and branch resolution
`default_nettype none

module mips_execute import mips_isa_pkg::*; (
  input  logic      clk_1,
  input  logic      rst,
  input  logic      run,
  id_ex_if.receiver in,
  ex_mem_if.driver  out,
  output logic      redirect,
  output pc_t       redirect_pc
);

  opcode_e  op;
  word_t    alu_res;
  word_t    target;
  reg_idx_t dest;
  logic     a_zero;

  assign op     = op_of(in.instr);
  assign a_zero = in.a == '0;

  always_comb begin
    alu_res = in.a + in.imm;  // ADDI, LW, SW
    case (in.iclass)
      RR: begin
        case (op)
          SUB:     alu_res = in.a - in.b;
          AND:     alu_res = in.a & in.b;
          OR:      alu_res = in.a | in.b;
          SLT:     alu_res = word_t'($signed(in.a) < $signed(in.b));
          MUL:     alu_res = in.a * in.b;  // Low word only
          default: alu_res = in.a + in.b;
        endcase
      end
      RM: begin
        if (op == SUBI) alu_res = in.a - in.imm;
      end
      default: ;
    endcase
  end

  assign dest = (in.iclass == RR) ? rd_of(in.instr) : rt_of(in.instr);

  // Relative to the branch's NPC
  assign target      = word_t'(in.npc) + in.imm;
  assign redirect_pc = pc_t'(target);
  assign redirect    = run & in.valid & (in.iclass == BRANCH) & ((op == BEQZ) == a_zero);

  always_ff @(posedge clk_1 or negedge rst) begin
    if (!rst) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= run & in.valid;
    end
  end

  always_ff @(posedge clk_1) begin
    out.iclass     <= in.iclass;
    out.dest       <= dest;
    out.result     <= alu_res;
    out.store_data <= in.b;
  end

endmodule

`default_nettype wire

// File: hw/mips_memwb.sv
// Memory and writeback stage with data memory and halt detection
`default_nettype none

`include "mips_defs.svh"

module mips_memwb import mips_isa_pkg::*; (
  input  logic       clk_1,
  input  logic       rst,
  input  logic       run,
  ex_mem_if.receiver in,
  host_mem_if.dmem   host,
  output logic       wb_en,
  output reg_idx_t   wb_idx,
  output word_t      wb_data,
  output logic       halt_seen
);

  word_t  dmem [`MIPS_DMEM_DEPTH];
  logic   halt_done;
  logic   active;
  daddr_t core_addr;
  word_t  load_word;

  assign active    = run & ~halt_done & in.valid;
  assign core_addr = daddr_t'(in.result);
  assign load_word = dmem[core_addr];

  assign halt_seen = active & (in.iclass == HALT);
  assign wb_en     = active & (in.iclass inside {RR, RM, LOAD});
  assign wb_idx    = in.dest;
  assign wb_data   = (in.iclass == LOAD) ? load_word : in.result;

  assign host.dmem_rdata = host.dmem_re ? dmem[host.addr] : '0;

  // Core owns the write port only while running
  always_ff @(posedge clk_1) begin
    if (run) begin
      if (active && in.iclass == STORE) dmem[core_addr] <= in.store_data;
    end else if (host.dmem_we) begin
      dmem[host.addr] <= host.wdata;
    end
  end

  // Blocks younger instructions until run drops
  always_ff @(posedge clk_1 or negedge rst) begin
    if (!rst) begin
      halt_done <= 1'b0;
    end else if (!run) begin
      halt_done <= 1'b0;
    end else if (halt_seen) begin
      halt_done <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/mips_core_top.sv
// MIPS core top level with APB host port and halt status
`default_nettype none

module mips_core_top import mips_isa_pkg::*, mips_bus_pkg::*; (
  input  logic   clk_1,
  input  logic   rst,
  input  paddr_t paddr,
  input  logic   psel,
  input  logic   penable,
  input  logic   pwrite,
  input  pdata_t pwdata,
  output pdata_t prdata,
  output logic   pready,
  output logic   pslverr,
  output logic   halted
);

  if_id_if    u_if_id ();
  id_ex_if    u_id_ex ();
  ex_mem_if   u_ex_mem ();
  host_mem_if u_host ();

  reg_idx_t host_reg_idx;
  word_t    host_reg_rdata;
  reg_idx_t rs_idx;
  reg_idx_t rt_idx;
  word_t    rs_data;
  word_t    rt_data;
  logic     wb_en;
  reg_idx_t wb_idx;
  word_t    wb_data;
  logic     run;
  logic     halt_seen;
  logic     redirect;
  pc_t      redirect_pc;

  apb_mem_port u_apb (
    .clk_1(clk_1), .rst(rst),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .host(u_host.master),
    .reg_idx(host_reg_idx), .reg_rdata(host_reg_rdata),
    .halt_seen(halt_seen), .run(run), .halted(halted)
  );

  mips_fetch u_fetch (
    .clk_1(clk_1), .rst(rst), .run(run), .host(u_host.imem_wr),
    .redirect(redirect), .redirect_pc(redirect_pc), .out(u_if_id.driver)
  );

  mips_regfile u_regfile (
    .clk_1(clk_1), .rst(rst),
    .rs_idx(rs_idx), .rt_idx(rt_idx), .rs_data(rs_data), .rt_data(rt_data),
    .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data),
    .reg_idx(host_reg_idx), .reg_rdata(host_reg_rdata)
  );

  mips_decode u_decode (
    .clk_1(clk_1), .rst(rst), .run(run), .redirect(redirect),
    .in(u_if_id.receiver),
    .rs_idx(rs_idx), .rt_idx(rt_idx), .rs_data(rs_data), .rt_data(rt_data),
    .out(u_id_ex.driver)
  );

  mips_execute u_execute (
    .clk_1(clk_1), .rst(rst), .run(run),
    .in(u_id_ex.receiver), .out(u_ex_mem.driver),
    .redirect(redirect), .redirect_pc(redirect_pc)
  );

  mips_memwb u_memwb (
    .clk_1(clk_1), .rst(rst), .run(run),
    .in(u_ex_mem.receiver), .host(u_host.dmem),
    .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data), .halt_seen(halt_seen)
  );

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
// Clock and reset source for the MIPS core testbench
`default_nettype none

module tb_clock (
  output logic clk_1,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 4;

  initial begin
    clk_1 = 1'b0;
    forever #10 clk_1 = ~clk_1;  // 20 ns period
  end

  initial begin
    rst = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_1);
    rst <= 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/tb_top.sv
// MIPS core testbench with random programs, APB host driver and ISA model
`default_nettype none

`include "mips_defs.svh"

module tb_top import mips_isa_pkg::*, mips_bus_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 100;
  localparam int RUN_LIMIT  = 20000;

  logic   clk_1;
  logic   rst;
  paddr_t paddr;
  logic   psel;
  logic   penable;
  logic   pwrite;
  pdata_t pwdata;
  pdata_t prdata;
  logic   pready;
  logic   pslverr;
  logic   halted;

  word_t  mregs [`MIPS_NUM_REGS];
  word_t  mdmem [`MIPS_DMEM_DEPTH];
  instr_t prog [$];

  tb_clock u_clock (.clk_1(clk_1), .rst(rst));

  mips_core_top dut0 (
    .clk_1(clk_1), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .halted(halted)
  );

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) abort_run($sformatf("Error %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_state(string name, run_state_e got, run_state_e exp);
    if (got !== exp) abort_run($sformatf("Error %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_err(string name, logic got, logic exp);
    if (got !== exp) abort_run($sformatf("Error %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  // One APB transfer, sampled at the falling edge of the access phase
  task automatic apb_access(input logic wr, input paddr_t addr, input pdata_t wdata,
                            output pdata_t rdata, output logic err);
    int n;
    @(posedge clk_1);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk_1);
    penable <= 1'b1;
    n = 0;
    @(negedge clk_1);
    while (!pready && n < WAIT_LIMIT) begin
      @(negedge clk_1);
      n++;
    end
    if (!pready) abort_run("Timeout waiting for pready");
    rdata = prdata;
    err   = pslverr;
    @(posedge clk_1);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(paddr_t addr, pdata_t data);
    pdata_t rd;
    logic   err;
    apb_access(1'b1, addr, data, rd, err);
    check_err("pslverr", err, 1'b0);
  endtask

  task automatic apb_read(input paddr_t addr, output pdata_t data);
    logic err;
    apb_access(1'b0, addr, '0, data, err);
    check_err("pslverr", err, 1'b0);
  endtask

  function automatic instr_t make_rr(opcode_e op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
    return {op, rs, rt, rd, 11'd0};
  endfunction

  function automatic instr_t make_imm(opcode_e op, reg_idx_t rt, reg_idx_t rs, imm_t imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic reg_idx_t rnd_reg();
    return reg_idx_t'($urandom_range(31));
  endfunction

  function automatic void set_reg(reg_idx_t idx, word_t val);
    if (idx != 0) mregs[idx] = val;
  endfunction

  task automatic emit(instr_t i, int gap);
    prog.push_back(i);
    repeat (gap) prog.push_back(32'h0);  // ADD r0, r0, r0
  endtask

  // HLT, then a tail that must never retire
  task automatic end_program();
    emit(make_imm(HLT, 0, 0, 0), 0);
    emit(make_imm(ADDI, 5'd31, 5'd31, 16'h0077), 0);
    emit(make_imm(ADDI, 5'd7, 5'd7, 16'h0001), 0);
    emit(make_imm(SW, 5'd31, 5'd0, imm_t'($urandom_range(511))), 0);
    emit(make_imm(ADDI, 5'd1, 5'd1, 16'h0100), 0);
  endtask

  task automatic gen_alu_program(int count);
    opcode_e op;
    prog.delete();
    for (int r = 1; r < `MIPS_NUM_REGS; r++) begin
      emit(make_imm(LW, reg_idx_t'(r), 5'd0, imm_t'($urandom_range(511))), 0);
    end
    emit(32'h0, 2);
    for (int k = 0; k < count; k++) begin
      if ($urandom_range(1)) begin
        op = opcode_e'($urandom_range(5));  // ADD through MUL
        emit(make_rr(op, rnd_reg(), rnd_reg(), rnd_reg()), 3);
      end else begin
        op = $urandom_range(1) ? ADDI : SUBI;
        emit(make_imm(op, rnd_reg(), rnd_reg(), imm_t'($urandom)), 3);
      end
    end
    end_program();
  endtask

  task automatic gen_mem_program(int count);
    opcode_e op;
    prog.delete();
    for (int k = 0; k < count; k++) begin
      op = $urandom_range(1) ? LW : SW;
      emit(make_imm(op, rnd_reg(), rnd_reg(), imm_t'($urandom)), 3);
    end
    end_program();
  endtask

  // Condition set from r0, branch forward over up to three markers
  task automatic gen_branch_program(int count);
    reg_idx_t cond;
    opcode_e  op;
    imm_t     val;
    prog.delete();
    for (int k = 0; k < count; k++) begin
      cond = reg_idx_t'($urandom_range(5, 1));
      val  = $urandom_range(1) ? imm_t'($urandom) : 16'h0;
      op   = $urandom_range(1) ? BEQZ : BNEQZ;
      emit(make_imm(ADDI, cond, 5'd0, val), 3);
      emit(make_imm(op, 5'd0, cond, imm_t'($urandom_range(3, 1))), 0);
      for (int m = 0; m < 3; m++) begin
        emit(make_imm(ADDI, reg_idx_t'($urandom_range(29, 20)), 5'd0, imm_t'($urandom)), 0);
      end
    end
    end_program();
  endtask

  // Sequential reference, one instruction per step
  task automatic model_run();
    int       pc;
    int       n;
    bit       done;
    instr_t   i;
    opcode_e  op;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    word_t    a;
    word_t    b;
    word_t    imm;
    daddr_t   addr;
    pc   = 0;
    n    = 0;
    done = 1'b0;
    while (!done && n < RUN_LIMIT) begin
      if (pc >= prog.size()) abort_run("Model ran past the end of the program");
      i    = prog[pc];
      op   = opcode_e'(i[31:26]);
      rs   = i[25:21];
      rt   = i[20:16];
      rd   = i[15:11];
      a    = mregs[rs];
      b    = mregs[rt];
      imm  = {{16{i[15]}}, i[15:0]};
      addr = daddr_t'(a + imm);
      pc++;
      n++;
      case (op)
        ADD:   set_reg(rd, a + b);
        SUB:   set_reg(rd, a - b);
        AND:   set_reg(rd, a & b);
        OR:    set_reg(rd, a | b);
        SLT:   set_reg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        MUL:   set_reg(rd, a * b);
        LW:    set_reg(rt, mdmem[addr]);
        SW:    mdmem[addr] = b;
        ADDI:  set_reg(rt, a + imm);
        SUBI:  set_reg(rt, a - imm);
        BEQZ:  if (a == 0) pc = pc + int'($signed(imm));
        BNEQZ: if (a != 0) pc = pc + int'($signed(imm));
        HLT:   done = 1'b1;
        default: ;
      endcase
    end
    if (!done) abort_run("Model did not reach HLT");
  endtask

  task automatic fill_dmem();
    word_t v;
    for (int k = 0; k < `MIPS_DMEM_DEPTH; k++) begin
      v = $urandom;
      apb_write(paddr_t'(`MIPS_APB_DMEM_BASE + 4 * k), v);
      mdmem[k] = v;
    end
  endtask

  task automatic check_dmem();
    pdata_t v;
    for (int k = 0; k < `MIPS_DMEM_DEPTH; k++) begin
      apb_read(paddr_t'(`MIPS_APB_DMEM_BASE + 4 * k), v);
      check_word($sformatf("dmem[%0d]", k), v, mdmem[k]);
    end
  endtask

  task automatic check_regs();
    pdata_t v;
    for (int r = 0; r < `MIPS_NUM_REGS; r++) begin
      apb_read(paddr_t'(`MIPS_APB_REG_BASE + 4 * r), v);
      check_word($sformatf("reg[%0d]", r), v, mregs[r]);  // r0 model stays zero
    end
  endtask

  task automatic check_status(run_state_e exp);
    pdata_t v;
    apb_read(`MIPS_APB_CTRL_ADDR, v);
    check_state("run_state", run_state_e'(v[1:0]), exp);
  endtask

  task automatic load_program();
    foreach (prog[k]) apb_write(paddr_t'(`MIPS_APB_IMEM_BASE + 4 * k), prog[k]);
  endtask

  task automatic start_core();
    apb_write(`MIPS_APB_CTRL_ADDR, 32'h1);
  endtask

  task automatic wait_halted();
    int n;
    n = 0;
    @(negedge clk_1);
    while (!halted && n < RUN_LIMIT) begin
      @(negedge clk_1);
      n++;
    end
    if (!halted) abort_run("Timeout waiting for halted");
  endtask

  task automatic run_program();
    load_program();
    model_run();
    start_core();
    wait_halted();
    check_status(HALTED);
  endtask

  initial begin
    pdata_t rd;
    logic   err;
    int     n;
    int     k;
    paddr   <= '0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    pwdata  <= '0;
    void'($urandom(32'hf308_3b56));
    foreach (mregs[r]) mregs[r] = '0;
    n = 0;
    while (rst !== 1'b1 && n < WAIT_LIMIT) begin
      @(posedge clk_1);
      n++;
    end
    if (rst !== 1'b1) abort_run("Timeout waiting for reset release");
    @(negedge clk_1);
    check_err("halted", halted, 1'b0);
    check_err("pready", pready, 1'b0);
    check_err("pslverr", pslverr, 1'b0);
    check_status(IDLE);
    fill_dmem();
    check_dmem();

    gen_alu_program(60);
    run_program();
    check_regs();

    gen_mem_program(100);
    run_program();
    check_dmem();
    check_regs();

    gen_branch_program(40);  // Squashed markers and the HLT tail
    run_program();
    check_regs();
    check_dmem();

    // Host memory writes while running are refused
    gen_alu_program(60);
    load_program();
    model_run();
    start_core();
    apb_access(1'b1, `MIPS_APB_IMEM_BASE, make_imm(HLT, 0, 0, 0), rd, err);
    check_err("pslverr", err, 1'b1);
    k = $urandom_range(511);
    apb_access(1'b1, paddr_t'(`MIPS_APB_DMEM_BASE + 4 * k), ~mdmem[k], rd, err);
    check_err("pslverr", err, 1'b1);
    wait_halted();
    check_status(HALTED);
    check_dmem();
    check_regs();

    // Rerun on fresh seeds
    fill_dmem();
    model_run();
    start_core();
    wait_halted();
    check_status(HALTED);
    check_regs();

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
hw/mips_isa_pkg.sv
hw/mips_bus_pkg.sv
hw/mips_stage_if.sv
hw/apb_mem_port.sv
hw/mips_fetch.sv
hw/mips_regfile.sv
hw/mips_decode.sv
hw/mips_execute.sv
hw/mips_memwb.sv
hw/mips_core_top.sv
dv/tb_clock.sv
dv/tb_top.sv
